// ==== alu_stimulus.txt ====
# opcode a b expected_result expected_flags, all hex
# flags: 8 msb, 4 zero, 2 illegal opcode, 1 divide by zero
00 00000005 00000007 0000000C 0
00 FFFFFFFF 00000001 00000000 4
01 00000003 00000005 FFFFFFFE 8
02 F0F0F0F0 0FF00FF0 00F000F0 0
03 F0000000 0000000F F000000F 8
04 AAAAAAAA AAAAAAAA 00000000 4
05 00000001 00000024 00000010 0
06 80000000 0000001F 00000001 0
07 80000000 00000004 F8000000 8
08 FFFFFFFF 00000002 00000002 0
09 FFFFFFFF 00000002 FFFFFFFF 8
0A 0000F00F 12345678 00000008 0
0B 00010001 00010001 00020001 0
0C 12345678 12345678 11111111 0
0C FFFFFFFF 00000001 22222222 0
0C 00000001 FFFFFFFF 44444444 0
0D 00000064 00000007 0000000E 0
0E 00000064 00000007 00000002 0
0D FFFFFFFF 00000010 0FFFFFFF 0
0E FFFFFFFF 00000010 0000000F 0
0D 00001234 00000000 FFFFFFFF 9
0E 00001234 00000000 00001234 1
0F 00000001 00000002 DEADDEAD A
1F 00000000 00000000 DEADDEAD A
00 00000010 00000020 00000030 0

// ==== tb.f ====
+incdir+.
alu_op_pkg.sv
alu_link_pkg.sv
alu_decode.sv
alu_divider.sv
alu_execute.sv
alu_result.sv
alu_top.sv
tb_alu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu -f tb.f -o tb_alu_sim
./obj_dir/tb_alu_sim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi

// ==== tb_alu.sv ====
// ALU testbench running file vectors over both req/ack links and checking each result
`default_nettype none

`include "alu_defs.svh"

module tb_alu;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 5;

	logic clk;
	logic arst_n;
	logic req;
	logic ack;
	logic res_req;
	logic res_ack;
	alu_link_pkg::alu_req_t in;
	alu_link_pkg::alu_res_t res;

	// Vector columns from the stimulus file
	logic [4:0] vec_op[$];
	logic [`ALU_DW-1:0] vec_a[$];
	logic [`ALU_DW-1:0] vec_b[$];
	logic [`ALU_DW-1:0] vec_res[$];
	logic [3:0] vec_flags[$];

	integer seed;
	int errors;
	int n_pass;
	int n_fail;
	int cycles;
	int cycle_limit;

	alu_top uut
	(
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.in(in),
		.ack(ack),
		.res_req(res_req),
		.res(res),
		.res_ack(res_ack)
	);

	always #4 clk = ~clk;	// 8 ns period

	// Run limit from the vector count once the file is read
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ==================================================
	// Helpers
	// ==================================================

	task automatic check(input string name, input logic [`ALU_DW-1:0] got,
		input logic [`ALU_DW-1:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic protocol_error(input string what);
		$display("protocol error: %s", what);
		errors++;
	endtask

	task automatic load_vectors;
		int fd;
		string line;
		logic [31:0] op, a, b, r, f;
		fd = $fopen("alu_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file alu_stimulus.txt");
			errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != "#")
			begin
				if ($sscanf(line, "%h %h %h %h %h", op, a, b, r, f) == 5)
				begin
					vec_op.push_back(op[4:0]);
					vec_a.push_back(a);
					vec_b.push_back(b);
					vec_res.push_back(r);
					vec_flags.push_back(f[3:0]);
				end
			end
		end
		$fclose(fd);
		if (vec_op.size() == 0)
		begin
			$display("no vectors were read from the stimulus file");
			errors++;
		end
	endtask

	// One transaction on the input link and then on the output link
	task automatic run_vector(input int idx);
		int delay;
		int errs_before;
		alu_link_pkg::alu_res_t held;
		errs_before = errors;
		if (ack || res_req)	// Both pairs must be back low first
			protocol_error("link not idle before a new request");
		in.opcode = vec_op[idx];
		in.a      = vec_a[idx];
		in.b      = vec_b[idx];
		req       = 1'b1;
		@(negedge clk);
		while (!ack)
		begin
			if (res_req)
				protocol_error("res_req rose before the request was acknowledged");
			@(negedge clk);
		end
		req = 1'b0;
		@(negedge clk);
		while (ack)
			@(negedge clk);
		while (!res_req)
			@(negedge clk);
		held = res;
		check("res.word", res.word, vec_res[idx]);
		check("res.flags", {{(`ALU_DW-4){1'b0}}, res.flags},
			{{(`ALU_DW-4){1'b0}}, vec_flags[idx]});

		// Next request goes up early and has to wait for the output link
		if (idx + 1 < vec_op.size())
		begin
			in.opcode = vec_op[idx+1];
			in.a      = vec_a[idx+1];
			in.b      = vec_b[idx+1];
			req       = 1'b1;
		end

		// Consumer stalls and the result must hold
		delay = $random(seed) & 7;
		repeat (delay)
		begin
			@(negedge clk);
			if (!res_req || res !== held)
				protocol_error("res_req or res changed before res_ack");
			if (ack)
				protocol_error("ack rose while the previous result was still held");
		end
		res_ack = 1'b1;
		@(negedge clk);
		while (res_req)
			@(negedge clk);
		if (ack)
			protocol_error("ack rose before res_ack returned low");
		res_ack = 1'b0;
		@(negedge clk);
		if (ack)
			protocol_error("ack rose before the output link was back to idle");

		if (errors == errs_before)
		begin
			n_pass++;
			$display("test %0d opcode %h: pass", idx, vec_op[idx]);
		end
		else
		begin
			n_fail++;
			$display("test %0d opcode %h: fail", idx, vec_op[idx]);
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial
	begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		req         = 1'b0;
		res_ack     = 1'b0;
		in          = '0;
		seed        = 32'ha410;
		errors      = 0;
		n_pass      = 0;
		n_fail      = 0;
		cycles      = 0;
		cycle_limit = 1000;
		load_vectors();
		cycle_limit = vec_op.size() * (`ALU_DW + 20) + RESET_CYCLES + 2;

		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		if (ack || res_req)
			protocol_error("ack or res_req high after reset");

		for (int i = 0; i < vec_op.size(); i++)
			run_vector(i);

		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== alu_top.sv ====
// ALU top level: decode, execute and result stages between two req/ack links
`default_nettype none

module alu_top
(
	input  logic clk,
	input  logic arst_n,
	input  logic req,
	input  alu_link_pkg::alu_req_t in,
	output logic ack,
	output logic res_req,
	output alu_link_pkg::alu_res_t res,
	input  logic res_ack
);

	alu_op_pkg::alu_ctrl_t ctrl;
	alu_link_pkg::alu_res_t out;
	logic ctrl_valid;
	logic out_valid;
	logic free;	// Output link idle, next request may enter

	alu_decode u_decode
	(
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.in(in),
		.free(free),
		.ack(ack),
		.ctrl(ctrl),
		.ctrl_valid(ctrl_valid)
	);

	alu_execute u_execute
	(
		.clk(clk),
		.arst_n(arst_n),
		.ctrl(ctrl),
		.ctrl_valid(ctrl_valid),
		.out(out),
		.out_valid(out_valid)
	);

	alu_result u_result
	(
		.clk(clk),
		.arst_n(arst_n),
		.out(out),
		.out_valid(out_valid),
		.res_ack(res_ack),
		.res_req(res_req),
		.res(res),
		.free(free)
	);

endmodule

`default_nettype wire

// ==== alu_result.sv ====
// ALU result stage: result holding register and output four-phase handshake
`default_nettype none

module alu_result
(
	input  logic clk,
	input  logic arst_n,
	input  alu_link_pkg::alu_res_t out,
	input  logic out_valid,
	input  logic res_ack,
	output logic res_req,
	output alu_link_pkg::alu_res_t res,
	output logic free
);

	alu_link_pkg::link_state_e state;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= alu_link_pkg::link_idle;
		else
		begin
			case (state)
				alu_link_pkg::link_idle: if (out_valid) state <= alu_link_pkg::link_held;
				alu_link_pkg::link_held: if (res_ack) state <= alu_link_pkg::link_drop;
				alu_link_pkg::link_drop: if (!res_ack) state <= alu_link_pkg::link_idle;
				default: state <= alu_link_pkg::link_idle;
			endcase
		end
	end

	// Captured only from idle, so it stays put while res_req is up
	always_ff @(posedge clk)
	begin
		if (state == alu_link_pkg::link_idle && out_valid)
			res <= out;
	end

	assign res_req = (state == alu_link_pkg::link_held);
	assign free    = (state == alu_link_pkg::link_idle);	// Link fully back to rest

	a_res_held: assert property (@(posedge clk) disable iff (!arst_n)
		res_req && !res_ack |=> res_req && $stable(res))
		else $error("res_req or res changed before res_ack");

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
// ALU execute stage: single-cycle operations, divider sequencing and result flags
`default_nettype none

`include "alu_defs.svh"

module alu_execute
(
	input  logic clk,
	input  logic arst_n,
	input  alu_op_pkg::alu_ctrl_t ctrl,
	input  logic ctrl_valid,
	output alu_link_pkg::alu_res_t out,
	output logic out_valid
);

	alu_op_pkg::exec_state_e state;
	logic [`ALU_DW-1:0] single_word, fin_word;
	logic [`ALU_DW-1:0] quotient, remainder;
	logic [3:0] cmp_nib;
	logic div_by_zero, div_done, div_start;
	logic fin_dbz, load;

	function automatic logic [`ALU_DW-1:0] pop_count(input logic [`ALU_DW-1:0] v);
		logic [`ALU_DW-1:0] n;
		n = '0;
		for (int i = 0; i < `ALU_DW; i++)
			n = n + v[i];
		return n;
	endfunction

	// Compare nibble: 0, unsigned less, signed less, equal
	assign cmp_nib = {1'b0, ctrl.a < ctrl.b, $signed(ctrl.a) < $signed(ctrl.b),
		ctrl.a == ctrl.b};

	// ==================================================
	// Single-cycle operations
	// ==================================================

	always_comb
	begin
		case (ctrl.opcode)
			alu_op_pkg::op_add: single_word = ctrl.a + ctrl.b;
			alu_op_pkg::op_sub: single_word = ctrl.a - ctrl.b;
			alu_op_pkg::op_and: single_word = ctrl.a & ctrl.b;
			alu_op_pkg::op_or:  single_word = ctrl.a | ctrl.b;
			alu_op_pkg::op_xor: single_word = ctrl.a ^ ctrl.b;
			alu_op_pkg::op_shl: single_word = ctrl.a << ctrl.b[4:0];
			alu_op_pkg::op_shr: single_word = ctrl.a >> ctrl.b[4:0];
			alu_op_pkg::op_sra: single_word = $signed(ctrl.a) >>> ctrl.b[4:0];
			alu_op_pkg::op_min: single_word = (ctrl.a < ctrl.b) ? ctrl.a : ctrl.b;
			alu_op_pkg::op_max: single_word = (ctrl.a < ctrl.b) ? ctrl.b : ctrl.a;
			alu_op_pkg::op_pop: single_word = pop_count(ctrl.a);
			alu_op_pkg::op_mul: single_word = ctrl.a * ctrl.b;	// Low half only
			alu_op_pkg::op_cmp: single_word = {(`ALU_DW / 4){cmp_nib}};
			default:            single_word = `ALU_BAD_WORD;
		endcase
	end

	assign div_start = (state == alu_op_pkg::exec_ready) && ctrl_valid &&
		(ctrl.path == alu_op_pkg::path_divide);

	alu_divider u_div
	(
		.clk(clk),
		.arst_n(arst_n),
		.start(div_start),
		.dividend(ctrl.a),
		.divisor(ctrl.b),
		.quotient(quotient),
		.remainder(remainder),
		.div_by_zero(div_by_zero),
		.done(div_done)
	);

	// ==================================================
	// Result selection
	// ==================================================

	always_comb
	begin
		if (state == alu_op_pkg::exec_dividing)
		begin
			fin_word = (ctrl.opcode == alu_op_pkg::op_modu) ? remainder : quotient;
			fin_dbz  = div_by_zero;
		end
		else
		begin
			fin_word = single_word;
			fin_dbz  = 1'b0;
		end
	end

	assign load = (state == alu_op_pkg::exec_ready && ctrl_valid && !div_start) ||
		(state == alu_op_pkg::exec_dividing && div_done);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= alu_op_pkg::exec_ready;
		else if (div_start)
			state <= alu_op_pkg::exec_dividing;
		else if (load)
			state <= alu_op_pkg::exec_done;
		else if (state == alu_op_pkg::exec_done)
			state <= alu_op_pkg::exec_ready;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			out.word  <= fin_word;
			out.flags <= {fin_word[`ALU_DW-1], fin_word == '0,
				ctrl.path == alu_op_pkg::path_illegal, fin_dbz};
		end
	end

	assign out_valid = (state == alu_op_pkg::exec_done);	// One cycle per result

endmodule

`default_nettype wire

// ==== alu_divider.sv ====
// ALU divider: iterative restoring unsigned division, one quotient bit per cycle
`default_nettype none

`include "alu_defs.svh"

module alu_divider
(
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  logic [`ALU_DW-1:0] dividend,
	input  logic [`ALU_DW-1:0] divisor,
	output logic [`ALU_DW-1:0] quotient,
	output logic [`ALU_DW-1:0] remainder,
	output logic div_by_zero,
	output logic done
);

	logic busy;
	logic [`ALU_CNT_W-1:0] cnt;	// Steps already taken
	logic [`ALU_DW-1:0] rem_q, quo_q, dvs_q;
	logic [`ALU_DW-1:0] src_rem, src_quo, src_dvs;
	logic [`ALU_DW:0] partial, diff;

	// ==================================================
	// Step datapath
	// ==================================================

	// First step works straight from the inputs so start is step one
	always_comb
	begin
		src_rem = start ? '0 : rem_q;
		src_quo = start ? dividend : quo_q;
		src_dvs = start ? divisor : dvs_q;
		partial = {src_rem, src_quo[`ALU_DW-1]};
		diff    = partial - {1'b0, src_dvs};	// Sign bit set means restore
	end

	// A zero divisor never restores, giving all ones and the dividend back
	always_ff @(posedge clk)
	begin
		if (start || busy)
		begin
			rem_q <= diff[`ALU_DW] ? partial[`ALU_DW-1:0] : diff[`ALU_DW-1:0];
			quo_q <= {src_quo[`ALU_DW-2:0], ~diff[`ALU_DW]};
			dvs_q <= src_dvs;
		end
		if (start)
			div_by_zero <= (divisor == '0);
	end

	// ==================================================
	// Step control
	// ==================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				cnt  <= `ALU_CNT_W'(1);
			end
			else if (busy)
			begin
				cnt <= cnt + 1'b1;
				if (cnt == `ALU_CNT_W'(`ALU_DW - 1))	// Last step on this edge
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	assign quotient  = quo_q;
	assign remainder = rem_q;

	a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> !busy)
		else $error("divider started while running");

endmodule

`default_nettype wire

// ==== alu_decode.sv ====
// ALU decode stage: input four-phase handshake and opcode classification
`default_nettype none

module alu_decode
(
	input  logic clk,
	input  logic arst_n,
	input  logic req,
	input  alu_link_pkg::alu_req_t in,
	input  logic free,
	output logic ack,
	output alu_op_pkg::alu_ctrl_t ctrl,
	output logic ctrl_valid
);

	alu_link_pkg::link_state_e state;
	logic in_flight;	// Accepted, not yet picked up by the result stage
	logic take;

	function automatic alu_op_pkg::alu_path_e classify(input logic [4:0] code);
		case (alu_op_pkg::alu_opcode_e'(code))
			alu_op_pkg::op_divu, alu_op_pkg::op_modu:
				classify = alu_op_pkg::path_divide;
			alu_op_pkg::op_add, alu_op_pkg::op_sub, alu_op_pkg::op_and,
			alu_op_pkg::op_or, alu_op_pkg::op_xor, alu_op_pkg::op_shl,
			alu_op_pkg::op_shr, alu_op_pkg::op_sra, alu_op_pkg::op_min,
			alu_op_pkg::op_max, alu_op_pkg::op_pop, alu_op_pkg::op_mul,
			alu_op_pkg::op_cmp:
				classify = alu_op_pkg::path_single;
			default:
				classify = alu_op_pkg::path_illegal;
		endcase
	endfunction

	assign take = (state == alu_link_pkg::link_idle) && req && free && !in_flight;
	assign ack  = (state != alu_link_pkg::link_idle);	// High through held and drop

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state      <= alu_link_pkg::link_idle;
			ctrl_valid <= 1'b0;
			in_flight  <= 1'b0;
		end
		else
		begin
			ctrl_valid <= take;
			case (state)
				alu_link_pkg::link_idle: if (take) state <= alu_link_pkg::link_held;
				alu_link_pkg::link_held: if (!req) state <= alu_link_pkg::link_drop;
				default: state <= alu_link_pkg::link_idle;
			endcase
			// Result stage drops free once it holds our answer
			if (take)
				in_flight <= 1'b1;
			else if (!free)
				in_flight <= 1'b0;
		end
	end

	// Control payload, loaded once per transaction
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			ctrl.opcode <= alu_op_pkg::alu_opcode_e'(in.opcode);
			ctrl.path   <= classify(in.opcode);
			ctrl.a      <= in.a;
			ctrl.b      <= in.b;
		end
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose without req");

endmodule

`default_nettype wire

// ==== alu_link_pkg.sv ====
// ALU link types: request and result payloads and the four-phase handshake states
`default_nettype none

`include "alu_defs.svh"

package alu_link_pkg;

	// Raw request, opcode may hold an illegal code
	typedef struct packed
	{
		logic [4:0] opcode;
		logic [`ALU_DW-1:0] a;
		logic [`ALU_DW-1:0] b;
	} alu_req_t;

	// flags: 3 msb, 2 zero, 1 illegal opcode, 0 divide by zero
	typedef struct packed
	{
		logic [`ALU_DW-1:0] word;
		logic [3:0] flags;
	} alu_res_t;

	typedef enum logic [1:0]
	{
		link_idle,
		link_held,	// req/ack pair high
		link_drop	// Waiting for the far side to return low
	} link_state_e;

endpackage

`default_nettype wire

// ==== alu_op_pkg.sv ====
// ALU operation types: opcodes, execution paths, execute states and decoded control
`default_nettype none

`include "alu_defs.svh"

package alu_op_pkg;

	// Opcode codes, anything above op_modu is illegal
	typedef enum logic [4:0]
	{
		op_add  = 5'd0,
		op_sub  = 5'd1,
		op_and  = 5'd2,
		op_or   = 5'd3,
		op_xor  = 5'd4,
		op_shl  = 5'd5,
		op_shr  = 5'd6,
		op_sra  = 5'd7,
		op_min  = 5'd8,
		op_max  = 5'd9,
		op_pop  = 5'd10,
		op_mul  = 5'd11,
		op_cmp  = 5'd12,
		op_divu = 5'd13,
		op_modu = 5'd14
	} alu_opcode_e;

	typedef enum logic [1:0]
	{
		path_single,	// One-cycle result
		path_divide,	// Iterative divider
		path_illegal
	} alu_path_e;

	typedef enum logic [1:0]
	{
		exec_ready,
		exec_dividing,
		exec_done	// Result registered, out_valid high
	} exec_state_e;

	// Decoded instruction handed from decode to execute
	typedef struct packed
	{
		alu_opcode_e opcode;
		alu_path_e path;
		logic [`ALU_DW-1:0] a;
		logic [`ALU_DW-1:0] b;
	} alu_ctrl_t;

endpackage

`default_nettype wire

// ==== alu_defs.svh ====
// ALU shared defines for data width, divider step count and the illegal result word
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// ==================================================
// Datapath sizing
// ==================================================

// Width of operands and result word
`define ALU_DW 32

// Divider step counter, wide enough to count ALU_DW steps
`define ALU_CNT_W 6

// ==================================================
// Fixed result patterns
// ==================================================

// Returned for any opcode outside the legal set
`define ALU_BAD_WORD {(`ALU_DW / 16){16'hDEAD}}

`endif
